// File: dns_guard.f
+incdir+.
dns_guard_pkg.sv
sync_fifo.sv
ingress_classifier.sv
icmp_learn_parser.sv
request_queue.sv
verdict_gate.sv
egress_merge.sv
dns_guard_top.sv
tb_dns_guard.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dns_guard testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_dns_guard -f dns_guard.f -o sim_dns_guard &&
./obj_dir/sim_dns_guard ||
{ echo "simulation failed"; exit 1; }

// File: tb_dns_guard.sv
// directed testbench for dns_guard_top; models the lookup engine, which answers every query in order a few cycles later
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module tb_dns_guard;

	// five tests of far fewer than 1000 cycles each
	localparam int MAX_CYCLES    = 20000;
	localparam int WAIT_LIMIT    = 400;
	localparam int SETTLE_CYCLES = 40;
	localparam int ENGINE_DELAY  = 3;

	logic                       clk156;
	logic                       eth_rst;
	logic                       rx0_valid;
	dns_guard_pkg::axis_beat_t  rx0_beat;
	logic                       rx1_valid;
	dns_guard_pkg::axis_beat_t  rx1_beat;
	logic                       tx1_valid;
	dns_guard_pkg::axis_beat_t  tx1_beat;
	logic                       tx1_ready;
	logic                       in_valid;
	dns_guard_pkg::lookup_req_t in_req;
	logic                       out_valid;
	dns_guard_pkg::verdict_t    out_flag;

	logic [31:0]                pay_seed = 32'he948caf7;
	logic [31:0]                rdy_seed = 32'he948caf7;
	logic                       ready_random = 1'b0;
	int                         cycles = 0;
	logic [`DG_DATA_W-1:0]      fdata [32];
	int                         flen;
	dns_guard_pkg::axis_beat_t  tx_log [$];
	dns_guard_pkg::lookup_req_t req_log [$];
	dns_guard_pkg::axis_beat_t  exp_q [$];
	int                         exp_len [$];
	dns_guard_pkg::lookup_req_t exp_req [$];
	dns_guard_pkg::verdict_t    verdict_q [$];
	int                         due_q [$];

	dns_guard_top DUT (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.rx0_valid (rx0_valid),
		.rx0_beat  (rx0_beat),
		.rx1_valid (rx1_valid),
		.rx1_beat  (rx1_beat),
		.tx1_valid (tx1_valid),
		.tx1_beat  (tx1_beat),
		.tx1_ready (tx1_ready),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_flag  (out_flag)
	);

	initial begin
		clk156 = 1'b0;
		forever #2 clk156 = ~clk156;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	// tx1 beats, requests and engine schedule sampled on the rising edge
	always @(posedge clk156) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			abort_run("timeout: the run went past its cycle limit");
		end else begin
			if (!eth_rst && tx1_valid && tx1_ready)
				tx_log.push_back(tx1_beat);
			if (!eth_rst && in_valid) begin
				req_log.push_back(in_req);
				if (in_req.op == dns_guard_pkg::op_query)
					due_q.push_back(cycles + ENGINE_DELAY);
			end
		end
	end

	// lookup engine model
	initial begin
		out_valid = 1'b0;
		out_flag  = dns_guard_pkg::v_pass;
		forever begin
			@(negedge clk156);
			out_valid = 1'b0;
			if (due_q.size() > 0 && cycles >= due_q[0]) begin
				void'(due_q.pop_front());
				if (verdict_q.size() == 0) begin
					abort_run("lookup model got a query but the test gave no verdict for it");
				end else begin
					out_flag  = verdict_q.pop_front();
					out_valid = 1'b1;
				end
			end
		end
	end

	initial begin
		tx1_ready = 1'b1;
		forever begin
			@(negedge clk156);
			if (ready_random) begin
				rdy_seed  = lcg_step(rdy_seed);
				tx1_ready = rdy_seed[31];
			end else begin
				tx1_ready = 1'b1;
			end
		end
	end

	task automatic make_key(output dns_guard_pkg::flow_key_t k);
		pay_seed   = lcg_step(pay_seed);
		k.src_ip   = pay_seed;
		pay_seed   = lcg_step(pay_seed);
		k.dst_ip   = pay_seed;
		pay_seed   = lcg_step(pay_seed);
		k.src_port = pay_seed[31:16];
		k.dst_port = pay_seed[15:0];
	endtask

	task automatic build_payload(input int nbeats);
		flen = nbeats;
		for (int b = 0; b < nbeats; b++) begin
			pay_seed        = lcg_step(pay_seed);
			fdata[b][63:32] = pay_seed;
			pay_seed        = lcg_step(pay_seed);
			fdata[b][31:0]  = pay_seed;
		end
	endtask

	// pos counts bytes from the frame start, most significant byte first
	task automatic put_field(input int pos, input int n, input logic [31:0] v);
		for (int i = 0; i < n; i++)
			fdata[(pos + i) / 8][8 * ((pos + i) % 8) +: 8] = v[8 * (n - 1 - i) +: 8];
	endtask

	task automatic build_port0(input int nbeats, input logic [15:0] etype,
		input logic [7:0] proto, input dns_guard_pkg::flow_key_t k);
		build_payload(nbeats);
		put_field(12, 2, 32'(etype));
		put_field(23, 1, 32'(proto));
		put_field(26, 4, k.src_ip);
		put_field(30, 4, k.dst_ip);
		put_field(34, 2, 32'(k.src_port));
		put_field(36, 2, 32'(k.dst_port));
	endtask

	// quoted header sits behind the 8-byte ICMP header
	task automatic build_icmp(input logic [7:0] itype, input logic [7:0] code,
		input dns_guard_pkg::flow_key_t k);
		build_payload(14);
		put_field(12, 2, 32'h0800);
		put_field(23, 1, 32'h01);
		put_field(34, 1, 32'(itype));
		put_field(35, 1, 32'(code));
		put_field(51, 1, 32'h11);
		put_field(54, 4, k.src_ip);
		put_field(58, 4, k.dst_ip);
		put_field(62, 2, 32'(k.src_port));
		put_field(64, 2, 32'(k.dst_port));
	endtask

	// last beat keeps fewer lanes depending on the frame length
	function automatic dns_guard_pkg::axis_beat_t beat_at(input int b);
		dns_guard_pkg::axis_beat_t beat;
		beat.data = fdata[b];
		if (b == flen - 1)
			beat.keep = {(`DG_KEEP_W){1'b1}} >> (flen % `DG_KEEP_W);
		else
			beat.keep = {(`DG_KEEP_W){1'b1}};
		beat.last = b == flen - 1;
		return beat;
	endfunction

	task automatic expect_frame();
		for (int b = 0; b < flen; b++)
			exp_q.push_back(beat_at(b));
		exp_len.push_back(flen);
	endtask

	task automatic expect_req(input dns_guard_pkg::lookup_op_t op,
		input dns_guard_pkg::flow_key_t k);
		dns_guard_pkg::lookup_req_t r;
		r.op  = op;
		r.key = k;
		exp_req.push_back(r);
	endtask

	// leaves the last beat driven so the next frame follows back to back
	task automatic send_frame(input int port);
		for (int b = 0; b < flen; b++) begin
			@(negedge clk156);
			if (port == 0) begin
				rx0_valid = 1'b1;
				rx0_beat  = beat_at(b);
			end else begin
				rx1_valid = 1'b1;
				rx1_beat  = beat_at(b);
			end
		end
	endtask

	task automatic stop_inputs();
		@(negedge clk156);
		rx0_valid = 1'b0;
		rx1_valid = 1'b0;
	endtask

	task automatic start_test();
		tx_log.delete();
		req_log.delete();
		exp_q.delete();
		exp_len.delete();
		exp_req.delete();
		verdict_q.delete();
	endtask

	task automatic wait_traffic(input int nbeats, input int nreqs);
		int waited;
		waited = 0;
		while (tx_log.size() < nbeats || req_log.size() < nreqs) begin
			if (waited >= WAIT_LIMIT) begin
				abort_run($sformatf("timeout: no %0d tx1 beats and %0d requests after %0d cycles",
					nbeats, nreqs, waited));
			end else begin
				@(negedge clk156);
				waited++;
			end
		end
		// anything extra shows up in the counts
		repeat (SETTLE_CYCLES) @(negedge clk156);
	endtask

	task automatic compare_in_order();
		check("tx1 beat count", 128'(tx_log.size()), 128'(exp_q.size()));
		for (int i = 0; i < exp_q.size(); i++)
			check("tx1_beat", 128'(tx_log[i]), 128'(exp_q[i]));
	endtask

	task automatic compare_requests();
		check("request count", 128'(req_log.size()), 128'(exp_req.size()));
		for (int i = 0; i < exp_req.size(); i++)
			check("in_req", 128'(req_log[i]), 128'(exp_req[i]));
	endtask

	// frames may leave in any order but each whole and once
	task automatic compare_by_frame();
		int          pos;
		int          start;
		int          hit;
		logic [15:0] used;
		pos  = 0;
		used = '0;
		check("tx1 beat count", 128'(tx_log.size()), 128'(exp_q.size()));
		while (pos < tx_log.size()) begin
			hit   = -1;
			start = 0;
			for (int k = 0; k < exp_len.size(); k++) begin
				if (hit < 0 && !used[k] && exp_q[start].data == tx_log[pos].data)
					hit = k;
				if (hit < 0)
					start += exp_len[k];
			end
			if (hit < 0) begin
				abort_run($sformatf("tx1 frame starting at beat %0d matches no sent frame", pos));
			end else begin
				used[hit] = 1'b1;
				for (int i = 0; i < exp_len[hit]; i++)
					check("tx1_beat", 128'(tx_log[pos + i]), 128'(exp_q[start + i]));
				pos += exp_len[hit];
			end
		end
	endtask

	task automatic test_bypass();
		dns_guard_pkg::flow_key_t k;
		start_test();
		make_key(k);
		// ARP frame carrying the UDP protocol byte
		build_port0(8, 16'h0806, 8'h11, k);
		expect_frame();
		send_frame(0);
		make_key(k);
		build_port0(9, 16'h0800, 8'h06, k);
		expect_frame();
		send_frame(0);
		stop_inputs();
		wait_traffic(17, 0);
		compare_in_order();
		compare_requests();
	endtask

	task automatic test_single_query();
		dns_guard_pkg::flow_key_t k;
		start_test();
		make_key(k);
		build_port0(10, 16'h0800, 8'h11, k);
		expect_frame();
		expect_req(dns_guard_pkg::op_query, k);
		verdict_q.push_back(dns_guard_pkg::v_pass);
		send_frame(0);
		stop_inputs();
		wait_traffic(10, 1);
		compare_in_order();
		compare_requests();
	endtask

	task automatic test_verdict_train();
		dns_guard_pkg::flow_key_t k;
		start_test();
		verdict_q.push_back(dns_guard_pkg::v_pass);
		verdict_q.push_back(dns_guard_pkg::v_drop);
		verdict_q.push_back(dns_guard_pkg::v_pass);
		for (int f = 0; f < 3; f++) begin
			make_key(k);
			build_port0(9, 16'h0800, 8'h11, k);
			expect_req(dns_guard_pkg::op_query, k);
			if (f != 1)
				expect_frame();
			send_frame(0);
		end
		stop_inputs();
		wait_traffic(18, 3);
		compare_in_order();
		compare_requests();
	endtask

	task automatic test_learn();
		dns_guard_pkg::flow_key_t k;
		start_test();
		make_key(k);
		build_icmp(8'h03, 8'h03, k);
		expect_req(dns_guard_pkg::op_learn, k);
		send_frame(1);
		make_key(k);
		build_icmp(8'h03, 8'h0a, k);
		expect_req(dns_guard_pkg::op_learn, k);
		send_frame(1);
		// echo request
		make_key(k);
		build_icmp(8'h08, 8'h00, k);
		send_frame(1);
		stop_inputs();
		wait_traffic(0, 2);
		compare_requests();
		compare_in_order();
	endtask

	task automatic test_mixed_stall();
		dns_guard_pkg::flow_key_t k;
		start_test();
		@(posedge clk156);
		ready_random = 1'b1;
		verdict_q.push_back(dns_guard_pkg::v_pass);
		verdict_q.push_back(dns_guard_pkg::v_pass);
		for (int f = 0; f < 4; f++) begin
			make_key(k);
			if (f % 2 == 0) begin
				build_port0(9 + f / 2, 16'h0800, 8'h11, k);
				expect_req(dns_guard_pkg::op_query, k);
			end else begin
				build_port0(8 + f / 2, f == 1 ? 16'h0806 : 16'h0800, 8'h06, k);
			end
			expect_frame();
			send_frame(0);
		end
		stop_inputs();
		wait_traffic(36, 2);
		@(posedge clk156);
		ready_random = 1'b0;
		compare_by_frame();
		compare_requests();
	endtask

	initial begin
		eth_rst   = 1'b1;
		rx0_valid = 1'b0;
		rx0_beat  = '0;
		rx1_valid = 1'b0;
		rx1_beat  = '0;
		repeat (2) @(negedge clk156);
		eth_rst = 1'b0;
		test_bypass();
		test_single_query();
		test_verdict_train();
		test_learn();
		test_mixed_stall();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: dns_guard_top.sv
// DNS reflection guard top; rx inputs have no back-pressure and the lookup engine must answer queries in order
`timescale 1ns/1ps

module dns_guard_top (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       rx0_valid,
	input  dns_guard_pkg::axis_beat_t  rx0_beat,
	input  logic                       rx1_valid,
	input  dns_guard_pkg::axis_beat_t  rx1_beat,
	output logic                       tx1_valid,
	output dns_guard_pkg::axis_beat_t  tx1_beat,
	input  logic                       tx1_ready,
	output logic                       in_valid,
	output dns_guard_pkg::lookup_req_t in_req,
	input  logic                       out_valid,
	input  dns_guard_pkg::verdict_t    out_flag
);

	logic                       query_valid;
	dns_guard_pkg::lookup_req_t query_req;
	logic                       learn_valid;
	dns_guard_pkg::lookup_req_t learn_req;
	logic                       byp_valid;
	dns_guard_pkg::axis_beat_t  byp_beat;
	logic                       lkp_valid;
	dns_guard_pkg::axis_beat_t  lkp_beat;
	logic                       rel_valid;
	dns_guard_pkg::axis_beat_t  rel_beat;
	logic                       rel_ready;

	ingress_classifier u_classifier (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx0_valid   (rx0_valid),
		.rx0_beat    (rx0_beat),
		.query_valid (query_valid),
		.query_req   (query_req),
		.byp_valid   (byp_valid),
		.byp_beat    (byp_beat),
		.lkp_valid   (lkp_valid),
		.lkp_beat    (lkp_beat)
	);

	icmp_learn_parser u_learn (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx1_valid   (rx1_valid),
		.rx1_beat    (rx1_beat),
		.learn_valid (learn_valid),
		.learn_req   (learn_req)
	);

	request_queue u_req_queue (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.query_valid (query_valid),
		.query_req   (query_req),
		.learn_valid (learn_valid),
		.learn_req   (learn_req),
		.in_valid    (in_valid),
		.in_req      (in_req)
	);

	verdict_gate u_gate (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.lkp_valid (lkp_valid),
		.lkp_beat  (lkp_beat),
		.out_valid (out_valid),
		.out_flag  (out_flag),
		.rel_valid (rel_valid),
		.rel_beat  (rel_beat),
		.rel_ready (rel_ready)
	);

	egress_merge u_merge (
		.clk156    (clk156),
		.eth_rst   (eth_rst),
		.byp_valid (byp_valid),
		.byp_beat  (byp_beat),
		.rel_valid (rel_valid),
		.rel_beat  (rel_beat),
		.rel_ready (rel_ready),
		.tx1_valid (tx1_valid),
		.tx1_beat  (tx1_beat),
		.tx1_ready (tx1_ready)
	);

endmodule

// File: egress_merge.sv
// frame arbiter for tx1; one idle cycle between frames, bypass beats beyond the FIFO depth are lost
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module egress_merge (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      byp_valid,
	input  dns_guard_pkg::axis_beat_t byp_beat,
	input  logic                      rel_valid,
	input  dns_guard_pkg::axis_beat_t rel_beat,
	output logic                      rel_ready,
	output logic                      tx1_valid,
	output dns_guard_pkg::axis_beat_t tx1_beat,
	input  logic                      tx1_ready
);

	dns_guard_pkg::merge_state_t state;
	dns_guard_pkg::axis_beat_t   b_beat;
	logic                        b_empty;
	logic                        b_pop;
	logic                        last_byp;

	sync_fifo #(
		.WIDTH      ($bits(dns_guard_pkg::axis_beat_t)),
		.DEPTH_BITS (`DG_PKT_DEPTH_BITS)
	) u_byp_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.din     (byp_beat),
		.wr_en   (byp_valid),
		.rd_en   (b_pop),
		.dout    (b_beat),
		.full    (),
		.empty   (b_empty)
	);

	always_comb begin
		tx1_valid = 1'b0;
		tx1_beat  = b_beat;
		rel_ready = 1'b0;
		case (state)
			dns_guard_pkg::ms_bypass: tx1_valid = !b_empty;
			dns_guard_pkg::ms_gated: begin
				tx1_valid = rel_valid;
				tx1_beat  = rel_beat;
				rel_ready = tx1_ready;
			end
			default: ;
		endcase
	end

	assign b_pop = state == dns_guard_pkg::ms_bypass && !b_empty && tx1_ready;

	// alternate when both sources wait
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			state    <= dns_guard_pkg::ms_idle;
			last_byp <= 1'b0;
		end else begin
			case (state)
				dns_guard_pkg::ms_idle: begin
					if (!b_empty && (!rel_valid || !last_byp)) begin
						state    <= dns_guard_pkg::ms_bypass;
						last_byp <= 1'b1;
					end else if (rel_valid) begin
						state    <= dns_guard_pkg::ms_gated;
						last_byp <= 1'b0;
					end
				end
				default: begin
					if (tx1_valid && tx1_ready && tx1_beat.last)
						state <= dns_guard_pkg::ms_idle;
				end
			endcase
		end
	end

endmodule

// File: verdict_gate.sv
// holds lookup-path frames until their verdict; verdicts must arrive in frame order, one per frame
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module verdict_gate (
	input  logic                      clk156,
	input  logic                      eth_rst,
	input  logic                      lkp_valid,
	input  dns_guard_pkg::axis_beat_t lkp_beat,
	input  logic                      out_valid,
	input  dns_guard_pkg::verdict_t   out_flag,
	output logic                      rel_valid,
	output dns_guard_pkg::axis_beat_t rel_beat,
	input  logic                      rel_ready
);

	logic                      v_empty;
	logic                      v_pop;
	logic [`DG_FLAG_W-1:0]     v_flag;
	logic                      p_empty;
	logic                      p_pop;
	dns_guard_pkg::axis_beat_t p_beat;
	logic                      active;
	logic                      dropping;

	sync_fifo #(
		.WIDTH      (`DG_FLAG_W),
		.DEPTH_BITS (`DG_REQ_DEPTH_BITS)
	) u_verdict_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.din     (out_flag),
		.wr_en   (out_valid),
		.rd_en   (v_pop),
		.dout    (v_flag),
		.full    (),
		.empty   (v_empty)
	);

	sync_fifo #(
		.WIDTH      ($bits(dns_guard_pkg::axis_beat_t)),
		.DEPTH_BITS (`DG_PKT_DEPTH_BITS)
	) u_pkt_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.din     (lkp_beat),
		.wr_en   (lkp_valid),
		.rd_en   (p_pop),
		.dout    (p_beat),
		.full    (),
		.empty   (p_empty)
	);

	// next verdict is taken only between frames
	assign v_pop = !v_empty && !active;

	assign rel_valid = active && !dropping && !p_empty;
	assign rel_beat  = p_beat;

	// a dropped frame drains one beat per cycle
	assign p_pop = active && !p_empty && (dropping || rel_ready);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			active   <= 1'b0;
			dropping <= 1'b0;
		end else if (v_pop) begin
			active   <= 1'b1;
			dropping <= v_flag == dns_guard_pkg::v_drop;
		end else if (p_pop && p_beat.last) begin
			active   <= 1'b0;
			dropping <= 1'b0;
		end
	end

endmodule

// File: request_queue.sv
// request merge; a learn request colliding with a query while the hold register is busy overwrites the held one
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module request_queue (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       query_valid,
	input  dns_guard_pkg::lookup_req_t query_req,
	input  logic                       learn_valid,
	input  dns_guard_pkg::lookup_req_t learn_req,
	output logic                       in_valid,
	output dns_guard_pkg::lookup_req_t in_req
);

	logic                             hold_valid;
	dns_guard_pkg::lookup_req_t       hold_req;
	dns_guard_pkg::lookup_req_t       q_din;
	logic                             q_wr;
	logic                             q_empty;
	logic [`DG_FLAG_W+`DG_KEY_W-1:0] q_dout;

	// query first, then a held learn, then a fresh learn
	always_comb begin
		if (query_valid)
			q_din = query_req;
		else if (hold_valid)
			q_din = hold_req;
		else
			q_din = learn_req;
	end

	assign q_wr = query_valid || hold_valid || learn_valid;

	always_ff @(posedge clk156) begin
		if (eth_rst)
			hold_valid <= 1'b0;
		else if (learn_valid && (query_valid || hold_valid))
			hold_valid <= 1'b1;
		else if (!query_valid)
			hold_valid <= 1'b0;
	end

	always_ff @(posedge clk156) begin
		if (learn_valid)
			hold_req <= learn_req;
	end

	sync_fifo #(
		.WIDTH      (`DG_FLAG_W + `DG_KEY_W),
		.DEPTH_BITS (`DG_REQ_DEPTH_BITS)
	) u_req_fifo (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.din     (q_din),
		.wr_en   (q_wr),
		.rd_en   (in_valid),
		.dout    (q_dout),
		.full    (),
		.empty   (q_empty)
	);

	// one entry per cycle since the engine has no back-pressure
	assign in_valid = !q_empty;
	assign in_req   = dns_guard_pkg::lookup_req_t'(q_dout);

endmodule

// File: icmp_learn_parser.sv
// port-1 learn parser; only ICMP unreachable frames quoting a UDP header and at least 12 beats long produce a request
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module icmp_learn_parser (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       rx1_valid,
	input  dns_guard_pkg::axis_beat_t  rx1_beat,
	output logic                       learn_valid,
	output dns_guard_pkg::lookup_req_t learn_req
);

	logic [`DG_CNT_W-1:0]     cnt;
	logic [`DG_DATA_W-1:0]    d;
	logic [15:0]              ftype;
	logic [7:0]               ip_proto;
	logic [7:0]               icmp_type;
	logic [7:0]               icmp_code;
	logic [7:0]               q_proto;
	logic                     unreach;
	dns_guard_pkg::flow_key_t q_key;

	assign d = rx1_beat.data;

	assign unreach = ftype == `DG_ETH_IPV4 && ip_proto == `DG_PROTO_ICMP &&
		icmp_type == `DG_ICMP_UNREACH &&
		(icmp_code == `DG_CODE_PORT || icmp_code == `DG_CODE_ADMIN) &&
		q_proto == `DG_PROTO_UDP;

	assign learn_valid   = rx1_valid && unreach && cnt == `DG_LEARN_BEAT;
	assign learn_req.op  = dns_guard_pkg::op_learn;
	assign learn_req.key = q_key;

	always_ff @(posedge clk156) begin
		if (eth_rst || (rx1_valid && rx1_beat.last)) begin
			cnt       <= '0;
			ftype     <= '0;
			ip_proto  <= '0;
			icmp_type <= '0;
			icmp_code <= '0;
			q_proto   <= '0;
			q_key     <= '0;
		end else if (rx1_valid) begin
			if (cnt != '1)
				cnt <= cnt + 1'b1;
			case (cnt)
				1: ftype    <= {`DG_LANE(d, 4), `DG_LANE(d, 5)};
				2: ip_proto <= `DG_LANE(d, 7);
				4: begin
					icmp_type <= `DG_LANE(d, 2);
					icmp_code <= `DG_LANE(d, 3);
				end
				// quoted IP header starts in beat 5
				6: begin
					q_proto             <= `DG_LANE(d, 3);
					q_key.src_ip[31:16] <= {`DG_LANE(d, 6), `DG_LANE(d, 7)};
				end
				7: begin
					q_key.src_ip[15:0]  <= {`DG_LANE(d, 0), `DG_LANE(d, 1)};
					q_key.dst_ip        <= {`DG_LANE(d, 2), `DG_LANE(d, 3),
						`DG_LANE(d, 4), `DG_LANE(d, 5)};
					q_key.src_port      <= {`DG_LANE(d, 6), `DG_LANE(d, 7)};
				end
				8: q_key.dst_port <= {`DG_LANE(d, 0), `DG_LANE(d, 1)};
				default: ;
			endcase
		end
	end

endmodule

// File: ingress_classifier.sv
// port-0 parser and delay line; a frame whose beat 2 arrives after its beat 0 has left the line loses its early beats to bypass
`timescale 1ns/1ps
`include "dns_guard_defines.svh"

module ingress_classifier (
	input  logic                       clk156,
	input  logic                       eth_rst,
	input  logic                       rx0_valid,
	input  dns_guard_pkg::axis_beat_t  rx0_beat,
	output logic                       query_valid,
	output dns_guard_pkg::lookup_req_t query_req,
	output logic                       byp_valid,
	output dns_guard_pkg::axis_beat_t  byp_beat,
	output logic                       lkp_valid,
	output dns_guard_pkg::axis_beat_t  lkp_beat
);

	logic [`DG_CNT_W-1:0]        cnt;
	logic [`DG_DATA_W-1:0]       d;
	logic [15:0]                 ftype;
	logic                        frm_udp;
	logic                        udp_hit;
	logic                        in_last;
	dns_guard_pkg::flow_key_t    key;
	logic [`DG_DELAY_STAGES-1:0] ln_valid;
	logic [`DG_DELAY_STAGES-1:0] ln_udp;
	logic [`DG_DELAY_STAGES-2:0] ln_open;
	dns_guard_pkg::axis_beat_t   ln_beat [`DG_DELAY_STAGES];

	assign d       = rx0_beat.data;
	assign in_last = rx0_valid && rx0_beat.last;

	// beat 2 decides the class of the frame
	assign udp_hit = rx0_valid && cnt == 2 && ftype == `DG_ETH_IPV4 &&
		`DG_LANE(d, 7) == `DG_PROTO_UDP;

	assign query_valid   = rx0_valid && frm_udp && cnt == `DG_QUERY_BEAT;
	assign query_req.op  = dns_guard_pkg::op_query;
	assign query_req.key = key;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			cnt     <= '0;
			frm_udp <= 1'b0;
		end else if (rx0_valid) begin
			if (rx0_beat.last) begin
				cnt     <= '0;
				frm_udp <= 1'b0;
			end else begin
				if (cnt != '1)
					cnt <= cnt + 1'b1;
				if (udp_hit)
					frm_udp <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk156) begin
		if (rx0_valid) begin
			case (cnt)
				1: ftype <= {`DG_LANE(d, 4), `DG_LANE(d, 5)};
				3: begin
					key.src_ip         <= {`DG_LANE(d, 2), `DG_LANE(d, 3),
						`DG_LANE(d, 4), `DG_LANE(d, 5)};
					key.dst_ip[31:16]  <= {`DG_LANE(d, 6), `DG_LANE(d, 7)};
				end
				4: begin
					key.dst_ip[15:0]   <= {`DG_LANE(d, 0), `DG_LANE(d, 1)};
					key.src_port       <= {`DG_LANE(d, 2), `DG_LANE(d, 3)};
					key.dst_port       <= {`DG_LANE(d, 4), `DG_LANE(d, 5)};
				end
				default: ;
			endcase
		end
	end

	// open marks beats of the frame still arriving, so beats 0 and 1 get the tag late
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			ln_valid <= '0;
			ln_udp   <= '0;
			ln_open  <= '0;
		end else begin
			ln_valid <= {ln_valid[`DG_DELAY_STAGES-2:0], rx0_valid};
			ln_udp   <= {ln_udp[`DG_DELAY_STAGES-2:0] |
				(ln_open & {(`DG_DELAY_STAGES-1){udp_hit}}),
				frm_udp || udp_hit};
			ln_open  <= {ln_open[`DG_DELAY_STAGES-3:0] & {(`DG_DELAY_STAGES-2){!in_last}},
				rx0_valid && !rx0_beat.last};
		end
	end

	always_ff @(posedge clk156) begin
		ln_beat[0] <= rx0_beat;
		for (int i = 1; i < `DG_DELAY_STAGES; i++)
			ln_beat[i] <= ln_beat[i-1];
	end

	assign byp_valid = ln_valid[`DG_DELAY_STAGES-1] && !ln_udp[`DG_DELAY_STAGES-1];
	assign lkp_valid = ln_valid[`DG_DELAY_STAGES-1] && ln_udp[`DG_DELAY_STAGES-1];
	assign byp_beat  = ln_beat[`DG_DELAY_STAGES-1];
	assign lkp_beat  = ln_beat[`DG_DELAY_STAGES-1];

endmodule

// File: sync_fifo.sv
// first-word-fall-through FIFO of 2**DEPTH_BITS words; a write while full and a read while empty are ignored
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_BITS = 4
) (
	input  logic             clk156,
	input  logic             eth_rst,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             full,
	output logic             empty
);

	logic [WIDTH-1:0]    mem [2**DEPTH_BITS];
	logic [DEPTH_BITS:0] wr_ptr;
	logic [DEPTH_BITS:0] rd_ptr;

	// extra pointer bit tells full from empty
	assign empty = wr_ptr == rd_ptr;
	assign full  = wr_ptr[DEPTH_BITS] != rd_ptr[DEPTH_BITS] &&
		wr_ptr[DEPTH_BITS-1:0] == rd_ptr[DEPTH_BITS-1:0];
	assign dout  = mem[rd_ptr[DEPTH_BITS-1:0]];

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk156) begin
		if (wr_en && !full)
			mem[wr_ptr[DEPTH_BITS-1:0]] <= din;
	end

endmodule

// File: dns_guard_pkg.sv
// shared types; flow_key_t field order is the key layout that the lookup engine expects
`include "dns_guard_defines.svh"

package dns_guard_pkg;

	// one stream beat
	typedef struct packed {
		logic [`DG_DATA_W-1:0] data;
		logic [`DG_KEEP_W-1:0] keep;
		logic                  last;
	} axis_beat_t;

	// all fields in network byte order
	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
		logic [15:0] src_port;
	} flow_key_t;

	typedef enum logic [`DG_FLAG_W-1:0] {
		op_query = 4'b0000,
		op_learn = 4'b0101
	} lookup_op_t;

	typedef struct packed {
		lookup_op_t op;
		flow_key_t  key;
	} lookup_req_t;

	// anything but v_drop passes
	typedef enum logic [`DG_FLAG_W-1:0] {
		v_pass = 4'b0000,
		v_drop = 4'b0001
	} verdict_t;

	typedef enum logic [1:0] {
		ms_idle,
		ms_bypass,
		ms_gated
	} merge_state_t;

endpackage

// File: dns_guard_defines.svh
// sizes and header constants; beat counters are DG_CNT_W bits wide and saturate, so every request beat must stay below 2**DG_CNT_W-1
`ifndef DNS_GUARD_DEFINES_SVH
`define DNS_GUARD_DEFINES_SVH

// stream and lookup widths
`define DG_DATA_W 64
`define DG_KEEP_W 8
`define DG_KEY_W 96
`define DG_FLAG_W 4
`define DG_CNT_W 4

// buffering
`define DG_DELAY_STAGES 12
`define DG_REQ_DEPTH_BITS 5
`define DG_PKT_DEPTH_BITS 6

// header values
`define DG_ETH_IPV4 16'h0800
`define DG_PROTO_UDP 8'h11
`define DG_PROTO_ICMP 8'h01
`define DG_ICMP_UNREACH 8'h03
`define DG_CODE_PORT 8'h03
`define DG_CODE_ADMIN 8'h0a

// beat index of each request, counted from 0
`define DG_QUERY_BEAT 7
`define DG_LEARN_BEAT 11

// byte lane n of a data word, lane 0 first on the wire
`define DG_LANE(d, n) d[8*(n) +: 8]

`endif
